/* Makefile */
# Verilator build and run for the sign normalizer testbench

VERILATOR ?= verilator
TOP       ?= tb_sign_normalizer
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

EXE := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(EXE) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then echo "no pass line in log"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* lau_pkg.sv */
// ==============================
// shared types and widths for the sign normalizer
// import inside module bodies
// ==============================
`default_nettype none

package lau_pkg;

	// prefix network performance
	// SLOW is a serial ripple chain, FAST is log-depth Sklansky
	typedef enum logic [1:0] {
		SLOW = 2'd0,
		FAST = 2'd1
	} speed_e;

	// operand and result width
	localparam int DATA_W = 16;

	// shift count width, holds DATA_W-1
	localparam int SHIFT_W = 4;

	// speed handed down by the top level
	localparam speed_e SPEED = FAST;

endpackage

`default_nettype wire

/* lead_sign_det.sv */
// ==============================
// leading-sign detector, one-hot at the first bit
// below the sign that differs from it
// ==============================
`timescale 1ns/1ns
`default_nettype none

module lead_sign_det #(
	parameter int width = 8,
	parameter lau_pkg::speed_e speed = lau_pkg::FAST
) (
	input  logic [width-1:0] a,
	output logic [width-1:0] z
);

	import lau_pkg::*;

	// sign-equal marks, then their reversed forms
	logic [width-2:0] eq;
	logic [width-2:0] eq_rev;
	logic [width-2:0] run_rev;
	// run[i] set while bits width-2 down to i all equal the sign
	logic [width-2:0] run;

	// reject encodings outside speed_e and too-narrow words
	if (speed != SLOW && speed != FAST) begin : g_bad_speed
		$error("lead_sign_det: unsupported speed value");
	end
	if (width < 3) begin : g_bad_width
		$error("lead_sign_det: width must be at least 3");
	end

	for (genvar i = 0; i <= width - 2; i++) begin : g_eq
		assign eq[i] = ~(a[width-1] ^ a[i]);
		// flip so the prefix runs from the msb side
		assign eq_rev[i] = eq[width-2-i];
		assign run[i] = run_rev[width-2-i];
	end

	prefix_and #(
		.width(width - 1),
		.speed(speed)
	) u_prefix (
		.pi(eq_rev),
		.po(run_rev)
	);

	// sign position never flagged
	assign z[width-1] = 1'b0;
	assign z[width-2] = a[width-1] ^ a[width-2];

	// first mismatch: all above equal, this one differs
	for (genvar i = 0; i <= width - 3; i++) begin : g_z
		assign z[i] = run[i+1] & ~eq[i];
	end

endmodule

`default_nettype wire

/* norm_shifter.sv */
// ==============================
// stage 2, registered left barrel shift
// ==============================
`timescale 1ns/1ns
`default_nettype none

module norm_shifter (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        in_valid,
	input  logic [lau_pkg::DATA_W-1:0]  value,
	input  logic [lau_pkg::SHIFT_W-1:0] cnt,
	input  logic                        none,
	output logic                        out_valid,
	output logic [lau_pkg::DATA_W-1:0]  norm,
	output logic [lau_pkg::SHIFT_W-1:0] shift,
	output logic                        all_sign
);

	import lau_pkg::*;

	// stg[k] is value shifted by cnt[k-1:0]
	logic [DATA_W-1:0] stg [0:SHIFT_W];

	assign stg[0] = value;

	// one mux level per count bit
	for (genvar k = 0; k < SHIFT_W; k++) begin : g_lvl
		assign stg[k+1] = cnt[k] ? (stg[k] << (2 ** k)) : stg[k];
	end

	// valid bit
	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	// result word, count and flag
	always_ff @(posedge clk) begin
		if (in_valid) begin
			norm     <= stg[SHIFT_W];
			shift    <= cnt;
			all_sign <= none;
		end
	end

	// normalized result, top two bits differ
	a_norm_top: assert property (@(posedge clk) disable iff (rst)
		out_valid && !all_sign |-> norm[DATA_W-1] != norm[DATA_W-2])
	else $error("norm_shifter: result not normalized");

endmodule

`default_nettype wire

/* onehot_encode.sv */
// ==============================
// one-hot position to redundant-sign count
// ==============================
`timescale 1ns/1ns
`default_nettype none

module onehot_encode (
	input  logic [lau_pkg::DATA_W-1:0]  lsd,
	output logic [lau_pkg::SHIFT_W-1:0] cnt,
	output logic                        none
);

	import lau_pkg::*;

	// count for a hit at bit 0
	localparam logic [SHIFT_W-1:0] CNT_BASE = SHIFT_W'(DATA_W - 2);
	// count when only sign bits are present
	localparam logic [SHIFT_W-1:0] CNT_ALL = SHIFT_W'(DATA_W - 1);

	// bit index of the one-hot hit
	logic [SHIFT_W-1:0] pos;

	// or of indices, exact for a one-hot input
	always_comb begin
		pos = '0;
		for (int i = 0; i < DATA_W; i++) begin
			if (lsd[i]) begin
				pos = pos | SHIFT_W'(i);
			end
		end
	end

	// operand 0 or -1
	assign none = ~|lsd;

	// p = 14 maps to 0, p = 0 maps to 14
	always_comb begin
		if (none) begin
			cnt = CNT_ALL;
		end else begin
			cnt = CNT_BASE - pos;
		end
	end

endmodule

`default_nettype wire

/* prefix_and.sv */
// ==============================
// prefix-AND network, po[i] is the AND of pi[i:0]
// ==============================
`timescale 1ns/1ns
`default_nettype none

module prefix_and #(
	parameter int width = 8,
	parameter lau_pkg::speed_e speed = lau_pkg::FAST
) (
	input  logic [width-1:0] pi,
	output logic [width-1:0] po
);

	import lau_pkg::*;

	// number of Sklansky levels
	localparam int LEVELS = $clog2(width);

	if (speed == FAST) begin : g_fast
		// one vector per level, lvl[0] is the raw input
		logic [width-1:0] lvl [0:LEVELS];

		assign lvl[0] = pi;

		for (genvar l = 0; l < LEVELS; l++) begin : g_lvl
			for (genvar i = 0; i < width; i++) begin : g_bit
				// upper half of each 2^(l+1) block takes the top of the lower half
				if (((i >> l) & 1) == 1) begin : g_op
					assign lvl[l+1][i] = lvl[l][i] & lvl[l][((i >> l) << l) - 1];
				end else begin : g_pass
					assign lvl[l+1][i] = lvl[l][i];
				end
			end
		end

		assign po = lvl[LEVELS];
	end else begin : g_slow
		// ripple chain, depth grows with width
		assign po[0] = pi[0];

		for (genvar i = 1; i < width; i++) begin : g_chain
			assign po[i] = po[i-1] & pi[i];
		end
	end

endmodule

`default_nettype wire

/* project.f */
lau_pkg.sv
prefix_and.sv
lead_sign_det.sv
onehot_encode.sv
norm_shifter.sv
sign_normalizer.sv
tb_sign_normalizer.sv

/* sign_normalizer.sv */
// ==============================
// two-stage signed normalizer, top level
// strobe in, result 2 cycles later
// ==============================
`timescale 1ns/1ns
`default_nettype none

module sign_normalizer (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        in_valid,
	input  logic [lau_pkg::DATA_W-1:0]  operand,
	output logic                        out_valid,
	output logic [lau_pkg::DATA_W-1:0]  norm,
	output logic [lau_pkg::SHIFT_W-1:0] shift,
	output logic                        all_sign
);

	import lau_pkg::*;

	// stage 1 combinational results
	logic [DATA_W-1:0]  lsd;
	logic [SHIFT_W-1:0] cnt;
	logic               none;

	// stage 1 registers
	logic               s1_valid;
	logic [DATA_W-1:0]  s1_value;
	logic [SHIFT_W-1:0] s1_cnt;
	logic               s1_none;

	// detect first non-sign bit
	lead_sign_det #(
		.width(DATA_W),
		.speed(SPEED)
	) u_lsd (
		.a(operand),
		.z(lsd)
	);

	// position to count
	onehot_encode u_enc (
		.lsd(lsd),
		.cnt(cnt),
		.none(none)
	);

	// stage 1 valid
	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= in_valid;
		end
	end

	// operand with its count, held for the shifter
	always_ff @(posedge clk) begin
		if (in_valid) begin
			s1_value <= operand;
			s1_cnt   <= cnt;
			s1_none  <= none;
		end
	end

	// stage 2
	norm_shifter u_shift (
		.clk(clk),
		.rst(rst),
		.in_valid(s1_valid),
		.value(s1_value),
		.cnt(s1_cnt),
		.none(s1_none),
		.out_valid(out_valid),
		.norm(norm),
		.shift(shift),
		.all_sign(all_sign)
	);

	// fixed two-cycle latency once reset has left both stages
	a_latency: assert property (@(posedge clk) disable iff (rst)
		!$past(rst, 1) && !$past(rst, 2) |-> out_valid == $past(in_valid, 2))
	else $error("sign_normalizer: out_valid not in_valid delayed by 2");

	// zero and -1 report the full count
	a_all_sign_cnt: assert property (@(posedge clk) disable iff (rst)
		out_valid && all_sign |-> shift == SHIFT_W'(DATA_W - 1))
	else $error("sign_normalizer: all_sign with short shift");

endmodule

`default_nettype wire

/* tb_sign_normalizer.sv */
// ==============================
// self-checking testbench for the sign normalizer
// directed, back-to-back and random operands
// ==============================
`timescale 1ns/1ns
`default_nettype none

module tb_sign_normalizer;

	import lau_pkg::*;

	// packed reference result {all_sign, shift, norm}
	localparam int RES_W = 1 + SHIFT_W + DATA_W;

	logic               clk = 1'b0;
	logic               rst;
	logic               in_valid;
	logic [DATA_W-1:0]  operand;
	logic               out_valid;
	logic [DATA_W-1:0]  norm;
	logic [SHIFT_W-1:0] shift;
	logic               all_sign;

	// cycle counter that holds still at the falling edge
	int cyc = 0;
	int n_checked = 0;

	// operands in flight and the cycle each was issued in
	logic [DATA_W-1:0] op_q [$];
	int                stamp_q [$];

	sign_normalizer dut0 (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.operand(operand),
		.out_valid(out_valid),
		.norm(norm),
		.shift(shift),
		.all_sign(all_sign)
	);

	// 4 ns period
	initial begin
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// count bits equal to the sign while scanning down from below the msb
	function automatic logic [RES_W-1:0] exp_norm(input logic [DATA_W-1:0] v);
		int n;
		logic run;
		logic [DATA_W-1:0] w;
		n = 0;
		run = 1'b1;
		for (int i = DATA_W - 2; i >= 0; i--) begin
			if (run && v[i] == v[DATA_W-1]) begin
				n++;
			end else begin
				run = 1'b0;
			end
		end
		w = v << n;
		return {(n == DATA_W - 1), SHIFT_W'(n), w};
	endfunction

	task automatic stop_failed();
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic abort_run(input string msg);
		$display("ERROR at %0t ns: %s", $time, msg);
		stop_failed();
	endtask

	task automatic compare_val(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s got 0x%0h expected 0x%0h",
				$time, what, got, exp);
			stop_failed();
		end
	endtask

	// one strobe that stays up until the next edge
	task automatic send_op(input logic [DATA_W-1:0] v);
		@(posedge clk);
		in_valid <= 1'b1;
		operand  <= v;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			in_valid <= 1'b0;
		end
	endtask

	// hand-worked counts that anchor the reference
	task automatic send_directed(input logic [DATA_W-1:0] v, input int c);
		logic [RES_W-1:0] e;
		e = exp_norm(v);
		compare_val($sformatf("reference count for 0x%04h", v),
			32'(e[DATA_W +: SHIFT_W]), c);
		send_op(v);
	endtask

	// outputs sampled mid-cycle before the new input is recorded
	always @(negedge clk) begin : compare
		logic [RES_W-1:0]  e;
		logic [DATA_W-1:0] v;
		int                st;
		if (out_valid === 1'b1) begin
			if (op_q.size() == 0) begin
				abort_run("out_valid went high with no operand in flight");
			end else begin
				v = op_q.pop_front();
				st = stamp_q.pop_front();
				e = exp_norm(v);
				compare_val($sformatf("latency for 0x%04h", v), cyc - st, 32'd2);
				compare_val($sformatf("shift for 0x%04h", v),
					32'(shift), 32'(e[DATA_W +: SHIFT_W]));
				compare_val($sformatf("norm for 0x%04h", v),
					32'(norm), 32'(e[DATA_W-1:0]));
				compare_val($sformatf("all_sign for 0x%04h", v),
					32'(all_sign), 32'(e[RES_W-1]));
				n_checked++;
			end
		end else begin
			// also catches x on out_valid
			compare_val("out_valid while idle", 32'(out_valid), 32'd0);
			if (stamp_q.size() > 0 && cyc - stamp_q[0] >= 2) begin
				abort_run("out_valid never came for an issued operand");
			end
		end
		if (in_valid === 1'b1) begin
			op_q.push_back(operand);
			stamp_q.push_back(cyc);
		end
	end

	initial begin : stim
		logic [31:0]       seed;
		logic [DATA_W-1:0] v;
		int                gap;
		int                waited;
		rst = 1'b1;
		in_valid = 1'b0;
		operand = '0;
		seed = 32'd33468;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		// quiet period after reset with out_valid expected low
		idle_cycles(8);
		send_directed(16'h0005, 12);
		send_directed(16'hFFFA, 12);
		send_directed(16'h4000, 0);
		send_directed(16'hC000, 1);
		send_directed(16'h0001, 14);
		send_directed(16'h0000, 15);
		send_directed(16'hFFFF, 15);
		idle_cycles(3);
		// every detector position for both signs
		for (int k = 0; k < DATA_W; k++) begin
			send_op(16'(1) << k);
			send_op(~(16'(1) << k));
		end
		idle_cycles(4);
		// back-to-back strobes
		for (int i = 0; i < 200; i++) begin
			seed = lcg_next(seed);
			send_op(seed[31:16]);
		end
		idle_cycles(4);
		// random words, single-bit words and gaps
		for (int i = 0; i < 2000; i++) begin
			seed = lcg_next(seed);
			case (seed[15:14])
				2'd0: v = 16'(1) << seed[11:8];
				2'd1: v = ~(16'(1) << seed[11:8]);
				default: v = seed[31:16];
			endcase
			send_op(v);
			gap = (seed[3:0] >= 4'd11) ? int'(seed[6:4]) + 1 : 0;
			idle_cycles(gap);
		end
		idle_cycles(1);
		// drain the pipeline
		waited = 0;
		while (op_q.size() > 0 && waited < 20) begin
			@(posedge clk);
			waited++;
		end
		idle_cycles(3);
		if (op_q.size() == 0) begin
			$display("%0d results compared", n_checked);
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			$display("timeout: %0d results never arrived", op_q.size());
			stop_failed();
		end
	end

endmodule

`default_nettype wire
